/* dv/bp_tb.sv */
// assumes bp_top default parameters (INDEX_W 6, DEPTH 6); bursts never exceed DEPTH records in flight
`timescale 1ns/1ps
`default_nettype none

module bp_tb;

    import bp_pkg::*;

    localparam int IW    = 6;
    localparam int DEPTH = 6;

    logic        clk;
    logic        rstn;
    logic        pred_req;
    logic [29:0] pred_pc;
    logic        pred_valid;
    bp_pred_t    pred;
    logic [1:0]  res_valid;
    bp_resolve_t res0;
    bp_resolve_t res1;
    logic        upd_valid;
    bp_update_t  upd;

    int seed   = 32'h519fdbbb;
    int errors = 0;
    int checks = 0;
    int tests  = 0;
    int cyc;

    bp_cnt_t          m_pht [2**IW];
    bp_btb_t          m_btb [2**IW];
    logic [GHR_W-1:0] m_ghr;
    bp_update_t       exp_q [$];
    int               exp_cyc [$]; // edge on which each expected update was queued
    logic             exp_pvalid;
    bp_pred_t         exp_pred;
    logic             exp_due;
    bp_update_t       exp_front;

    bp_top i_bp_top (
        .clk(clk), .rstn(rstn), .pred_req(pred_req), .pred_pc(pred_pc),
        .pred_valid(pred_valid), .pred(pred), .res_valid(res_valid), .res0(res0), .res1(res1),
        .upd_valid(upd_valid), .upd(upd)
    );

    always #5 clk = ~clk;

    function automatic int kind_priority(input bp_kind_e k);
        case (k)
            direct_jump:   return 5;
            call:          return 4;
            ret:           return 3;
            indirect_jump: return 2;
            other_jump:    return 1;
            default:       return 0;
        endcase
    endfunction

    function automatic bp_update_t update_from(input bp_resolve_t r);
        bp_update_t u;
        u.pc    = r.ex.pc;
        u.taken = r.ex.taken;
        u.kind  = r.ex.kind;
        u.npc   = r.ex.npc;
        u.bh    = r.pred.bh;
        u.cnt   = r.pred.cnt;
        return u;
    endfunction

    function automatic bp_update_t merged_update(input bp_resolve_t a, input bp_resolve_t b);
        bp_update_t u;
        u       = update_from(a); // pc, bh and cnt stay with the older slot
        u.taken = a.ex.taken || b.ex.taken;
        u.kind  = (kind_priority(a.ex.kind) >= kind_priority(b.ex.kind)) ? a.ex.kind : b.ex.kind;
        u.npc   = a.ex.taken ? a.ex.npc : b.ex.npc;
        return u;
    endfunction

    function automatic void push_expected(input bp_update_t u);
        exp_q.push_back(u);
        exp_cyc.push_back(cyc);
    endfunction

    function automatic bp_resolve_t random_record();
        bp_resolve_t r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        a = $random(seed);
        b = $random(seed);
        c = $random(seed);
        r.pred.taken = a[30];
        r.pred.kind  = not_jump;
        r.pred.npc   = b[29:0];
        r.pred.bh    = a[13:0];
        r.pred.cnt   = a[15:14];
        r.ex.taken   = a[31];
        r.ex.kind    = bp_kind_e'(3'(a[23:16] % 8'd6));
        r.ex.npc     = c[29:0];
        r.ex.pc      = {b[31:30], c[31:30], a[29:24], b[29:10]};
        r.pack_size  = 1'b0;
        r.flush_pre  = 1'b0;
        return r;
    endfunction

    // cycle model reading pre-edge values like the DUT does
    always @(posedge clk) begin : model_step
        bp_update_t    u;
        bp_btb_t       e;
        logic [IW-1:0] idx;
        logic          hit;
        if (!rstn) begin
            for (int i = 0; i < 2**IW; i++) begin
                m_pht[i] = 2'b01;
                m_btb[i] = '0;
            end
            m_ghr = '0;
            exp_q.delete();
            exp_cyc.delete();
            exp_pvalid = 1'b0;
            exp_due    = 1'b0;
            exp_front  = '0;
            cyc        = 0;
        end else begin
            cyc++;
            exp_pvalid = pred_req;
            if (pred_req) begin // lookup before this edge's training lands
                idx            = pred_pc[IW-1:0] ^ m_ghr[IW-1:0];
                e              = m_btb[pred_pc[IW-1:0]];
                hit            = e.valid && (e.tag == pred_pc[IW+7:IW]);
                exp_pred.cnt   = m_pht[idx];
                exp_pred.bh    = m_ghr;
                exp_pred.taken = m_pht[idx][1] && hit;
                exp_pred.kind  = hit ? e.kind : not_jump;
                exp_pred.npc   = hit ? e.target : pred_pc + 30'd2;
            end
            if (upd_valid && exp_q.size() != 0) begin
                u = exp_q.pop_front();
                void'(exp_cyc.pop_front());
                idx = u.pc[IW-1:0] ^ u.bh[IW-1:0];
                if (u.taken) begin
                    m_pht[idx] = (u.cnt == 2'b11) ? 2'b11 : u.cnt + 2'b01;
                    m_btb[u.pc[IW-1:0]] = '{valid: 1'b1, tag: u.pc[IW+7:IW], kind: u.kind,
                                            target: u.npc};
                end else begin
                    m_pht[idx] = (u.cnt == 2'b00) ? 2'b00 : u.cnt - 2'b01;
                end
                m_ghr = {m_ghr[GHR_W-2:0], u.taken};
            end
            if (res_valid == 2'b11 && res0.pack_size && !res0.flush_pre) begin
                push_expected(merged_update(res0, res1));
            end else begin
                if (res_valid[0]) push_expected(update_from(res0));
                if (res_valid[1]) push_expected(update_from(res1));
            end
            exp_due   = (exp_q.size() != 0) && (exp_cyc[0] < cyc); // 2 edges after enqueue
            exp_front = (exp_q.size() != 0) ? exp_q[0] : '0;
        end
    end

    a_pred_valid: assert property (@(posedge clk) disable iff (!rstn) pred_valid == exp_pvalid)
        checks++;
    else begin
        errors++;
        $display("ERR %0t pred_valid exp %b got %b", $time, $sampled(exp_pvalid),
                 $sampled(pred_valid));
    end

    a_pred_value: assert property (@(posedge clk) disable iff (!rstn)
        pred_valid |-> pred == exp_pred) checks++;
    else begin
        errors++;
        $display("ERR %0t pred exp %h got %h", $time, $sampled(exp_pred), $sampled(pred));
    end

    a_upd_valid: assert property (@(posedge clk) disable iff (!rstn) upd_valid == exp_due)
        checks++;
    else begin
        errors++;
        $display("ERR %0t upd_valid exp %b got %b", $time, $sampled(exp_due), $sampled(upd_valid));
    end

    a_upd_value: assert property (@(posedge clk) disable iff (!rstn)
        upd_valid |-> upd == exp_front) checks++;
    else begin
        errors++;
        $display("ERR %0t upd exp %h got %h", $time, $sampled(exp_front), $sampled(upd));
    end

    task automatic drive_resolve(input logic [1:0] rv, input bp_resolve_t r0,
                                 input bp_resolve_t r1);
        @(posedge clk);
        res_valid <= rv;
        res0      <= r0;
        res1      <= r1;
    endtask

    task automatic predict(input logic [29:0] pc, output bp_pred_t p);
        int n;
        @(posedge clk);
        pred_req <= 1'b1;
        pred_pc  <= pc;
        @(posedge clk);
        pred_req <= 1'b0;
        @(negedge clk);
        n = 0;
        while (!pred_valid && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (!pred_valid) begin
            errors++;
            $display("timeout at %0t: no prediction came back for pc %h", $time, pc);
        end
        p = pred;
    endtask

    // idle the inputs, then wait for the model queue and upd_valid to empty
    task automatic drain(input string name);
        int n;
        @(posedge clk);
        res_valid <= 2'b00;
        pred_req  <= 1'b0;
        n = 0;
        @(negedge clk);
        while ((exp_q.size() != 0 || upd_valid) && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0 || upd_valid) begin
            errors++;
            $display("timeout at %0t: %s left updates pending", $time, name);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("%-20s finished, %0d errors so far", name, errors);
    endtask

    initial begin
        bp_resolve_t a;
        bp_resolve_t b;
        bp_pred_t    p;
        int          budget;
        int          pick;
        logic [29:0] pc;
        clk       = 1'b0;
        rstn      = 1'b0;
        pred_req  = 1'b0;
        pred_pc   = '0;
        res_valid = 2'b00;
        res0      = '0;
        res1      = '0;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;

        for (int i = 0; i < 4; i++) begin
            a = random_record();
            predict(a.ex.pc, p);
        end
        end_test("reset prediction");

        a = random_record();
        b = random_record();
        drive_resolve(2'b01, a, '0);
        drain("lane 0 single");
        drive_resolve(2'b10, '0, b);
        drain("lane 1 single");
        drive_resolve(2'b11, a, b);
        drive_resolve(2'b10, '0, a);
        drain("two singles");
        end_test("single records");

        for (int i = 0; i < 12; i++) begin
            a = random_record();
            b = random_record();
            a.pack_size = 1'b1;
            b.pack_size = 1'b1;
            drive_resolve(2'b11, a, b);
        end
        drain("pairs");
        end_test("paired records");

        for (int i = 0; i < 6; i++) begin
            a = random_record();
            b = random_record();
            drive_resolve(2'b11, a, b); // backlog so the next record queues behind the flushed one
            a = random_record();
            a.pack_size = 1'b1;
            a.flush_pre = 1'b1;
            drive_resolve(2'b01, a, '0);
            b = random_record();
            drive_resolve(2'b10, '0, b);
            drain("flushed slots");
        end
        end_test("flushed second slot");

        pc = 30'h0000_2a5c;
        for (int i = 0; i < 10; i++) begin
            predict(pc, p);
            a = random_record();
            a.pred     = p;
            a.ex.pc    = pc;
            a.ex.taken = 1'b1;
            a.ex.kind  = call;
            a.ex.npc   = 30'h0012_3400;
            drive_resolve(2'b01, a, '0);
            drain("training");
        end
        predict(pc, p);
        predict(pc ^ (30'd1 << IW), p); // same BTB slot, other tag
        end_test("training");

        for (int k = 0; k < 8; k++) begin
            budget = DEPTH;
            while (budget > 0) begin
                a    = random_record();
                b    = random_record();
                pick = {$random(seed)} % 6;
                if (pick == 3 && budget >= 2) begin
                    a.pack_size = 1'b1;
                    b.pack_size = 1'b1;
                    drive_resolve(2'b11, a, b);
                    budget -= 2;
                end else if (pick == 2 && budget >= 2) begin
                    drive_resolve(2'b11, a, b);
                    budget -= 2;
                end else if (pick == 1) begin
                    drive_resolve(2'b10, '0, b);
                    budget--;
                end else if (pick == 4) begin
                    a.pack_size = 1'b1;
                    a.flush_pre = 1'b1;
                    drive_resolve(2'b01, a, '0);
                    budget--;
                end else if (pick == 5) begin
                    drive_resolve(2'b00, '0, '0); // idle gap
                end else begin
                    drive_resolve(2'b01, a, '0);
                    budget--;
                end
                pred_req <= pick[0];
                pred_pc  <= b.ex.pc;
            end
            drain("burst");
        end
        end_test("bursts");

        $display("tests %0d, assertion checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
src/bp_pkg.sv
src/bp_table.sv
src/bp_predictor.sv
src/bp_update_buffer.sv
src/bp_updater.sv
src/bp_top.sv
dv/bp_tb.sv

/* src/bp_pkg.sv */
// record layouts are fixed by the 30-bit word pc and 14-bit history; INDEX_W must not exceed GHR_W
`default_nettype none

package bp_pkg;

    localparam int GHR_W = 14;
    localparam int TAG_W = 8;

    // merge priority runs direct_jump down to other_jump, not_jump last
    typedef enum logic [2:0] {
        not_jump      = 3'd0,
        direct_jump   = 3'd1,
        call          = 3'd2,
        ret           = 3'd3,
        indirect_jump = 3'd4,
        other_jump    = 3'd5
    } bp_kind_e;

    typedef logic [1:0] bp_cnt_t;

    localparam bp_cnt_t CNT_RESET = 2'b01; // weakly not taken

    typedef struct packed {
        logic             taken;
        bp_kind_e         kind;
        logic [29:0]      npc;
        logic [GHR_W-1:0] bh;  // history seen at lookup
        bp_cnt_t          cnt; // counter snapshot
    } bp_pred_t;

    typedef struct packed {
        logic        taken;
        bp_kind_e    kind;
        logic [29:0] npc;
        logic [29:0] pc;
    } bp_ex_t;

    typedef struct packed {
        bp_pred_t pred;
        bp_ex_t   ex;
        logic     pack_size; // block held two instructions
        logic     flush_pre; // later slot was flushed
    } bp_resolve_t;

    typedef struct packed {
        logic [29:0]      pc;
        logic             taken;
        bp_kind_e         kind;
        logic [29:0]      npc;
        logic [GHR_W-1:0] bh;
        bp_cnt_t          cnt;
    } bp_update_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        bp_kind_e         kind;
        logic [29:0]      target;
    } bp_btb_t;

    // gshare hash, caller keeps the low INDEX_W bits
    function automatic logic [GHR_W-1:0] bp_index(input logic [29:0] pc,
                                                  input logic [GHR_W-1:0] bh);
        return pc[GHR_W-1:0] ^ bh;
    endfunction

    // btb tag sits just above the index bits
    function automatic logic [TAG_W-1:0] bp_tag(input logic [29:0] pc, input int unsigned index_w);
        logic [29:0] shifted;
        shifted = pc >> index_w;
        return shifted[TAG_W-1:0];
    endfunction

endpackage

`default_nettype wire

/* src/bp_predictor.sv */
// one lookup per cycle, prediction valid exactly one cycle after pred_req; no bypass of same-cycle updates
`timescale 1ns/1ps
`default_nettype none

module bp_predictor #(
    parameter int INDEX_W = 6
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     pred_req,
    input  logic [29:0]              pred_pc,
    input  logic [bp_pkg::GHR_W-1:0] ghr,
    output logic [INDEX_W-1:0]       pht_addr,
    output logic [INDEX_W-1:0]       btb_addr,
    input  bp_pkg::bp_cnt_t          pht_data,
    input  bp_pkg::bp_btb_t          btb_data,
    output logic                     pred_valid,
    output bp_pkg::bp_pred_t         pred
);

    import bp_pkg::*;

    logic [GHR_W-1:0] pht_hash;
    logic             req_q;
    logic [29:0]      pc_q;
    logic [GHR_W-1:0] bh_q;
    logic             btb_hit;

    assign pht_hash = bp_index(pred_pc, ghr);
    assign pht_addr = pht_hash[INDEX_W-1:0];
    assign btb_addr = pred_pc[INDEX_W-1:0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_q <= 1'b0;
        end else begin
            req_q <= pred_req;
        end
    end

    // pc and history line up with the table read data
    always_ff @(posedge clk) begin
        if (pred_req) begin
            pc_q <= pred_pc;
            bh_q <= ghr;
        end
    end

    assign btb_hit = btb_data.valid && (btb_data.tag == bp_tag(pc_q, INDEX_W));

    always_comb begin
        pred.cnt   = pht_data;
        pred.bh    = bh_q;
        pred.taken = pht_data[1] && btb_hit;
        if (btb_hit) begin
            pred.kind = btb_data.kind;
            pred.npc  = btb_data.target;
        end else begin
            pred.kind = not_jump;
            pred.npc  = pc_q + 30'd2; // fall through past the block
        end
    end

    assign pred_valid = req_q;

endmodule

`default_nettype wire

/* src/bp_table.sv */
// registered read, old data on a same-address read and write; reset sweeps all 2**INDEX_W entries
`timescale 1ns/1ps
`default_nettype none

module bp_table #(
    parameter type    entry_t   = logic [1:0],
    parameter int     INDEX_W   = 6,
    parameter entry_t RESET_VAL = '0
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic [INDEX_W-1:0] rd_addr,
    input  logic [INDEX_W-1:0] wr_addr,
    input  logic               wr_en,
    input  entry_t             wr_data,
    output entry_t             rd_data
);

    localparam int ENTRIES = 2 ** INDEX_W;

    entry_t mem [ENTRIES];

    // every entry is cleared so a fresh table predicts from a known state
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < ENTRIES; i++) begin
                mem[i] <= RESET_VAL;
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr]; // sees the pre-write value
    end

endmodule

`default_nettype wire

/* src/bp_top.sv */
// update path runs open loop with no speculative history repair; DEPTH must cover the worst resolve burst
`timescale 1ns/1ps
`default_nettype none

module bp_top #(
    parameter int INDEX_W = 6,
    parameter int DEPTH   = 6
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                pred_req,
    input  logic [29:0]         pred_pc,
    output logic                pred_valid,
    output bp_pkg::bp_pred_t    pred,
    input  logic [1:0]          res_valid,
    input  bp_pkg::bp_resolve_t res0,
    input  bp_pkg::bp_resolve_t res1,
    output logic                upd_valid,
    output bp_pkg::bp_update_t  upd
);

    import bp_pkg::*;

    logic [INDEX_W-1:0] pht_rd_addr;
    logic [INDEX_W-1:0] btb_rd_addr;
    logic [INDEX_W-1:0] pht_wr_addr;
    logic [INDEX_W-1:0] btb_wr_addr;
    bp_cnt_t            pht_rd_data;
    bp_cnt_t            pht_wr_data;
    bp_btb_t            btb_rd_data;
    bp_btb_t            btb_wr_data;
    logic               pht_wr_en;
    logic               btb_wr_en;
    logic [GHR_W-1:0]   ghr;

    bp_predictor #(.INDEX_W(INDEX_W)) i_predictor (
        .clk(clk), .rstn(rstn), .pred_req(pred_req), .pred_pc(pred_pc), .ghr(ghr),
        .pht_addr(pht_rd_addr), .btb_addr(btb_rd_addr),
        .pht_data(pht_rd_data), .btb_data(btb_rd_data),
        .pred_valid(pred_valid), .pred(pred)
    );

    bp_update_buffer #(.DEPTH(DEPTH)) i_update_buffer (
        .clk(clk), .rstn(rstn), .res_valid(res_valid), .res0(res0), .res1(res1),
        .upd_valid(upd_valid), .upd(upd)
    );

    bp_updater #(.INDEX_W(INDEX_W)) i_updater (
        .clk(clk), .rstn(rstn), .upd_valid(upd_valid), .upd(upd),
        .pht_wr_en(pht_wr_en), .btb_wr_en(btb_wr_en),
        .pht_addr(pht_wr_addr), .btb_addr(btb_wr_addr),
        .pht_data(pht_wr_data), .btb_data(btb_wr_data), .ghr(ghr)
    );

    bp_table #(.entry_t(bp_cnt_t), .INDEX_W(INDEX_W), .RESET_VAL(CNT_RESET)) i_pht (
        .clk(clk), .rstn(rstn), .rd_addr(pht_rd_addr), .wr_addr(pht_wr_addr),
        .wr_en(pht_wr_en), .wr_data(pht_wr_data), .rd_data(pht_rd_data)
    );

    bp_table #(.entry_t(bp_btb_t), .INDEX_W(INDEX_W), .RESET_VAL('0)) i_btb (
        .clk(clk), .rstn(rstn), .rd_addr(btb_rd_addr), .wr_addr(btb_wr_addr),
        .wr_en(btb_wr_en), .wr_data(btb_wr_data), .rd_data(btb_rd_data)
    );

endmodule

`default_nettype wire

/* src/bp_update_buffer.sv */
// DEPTH >= 2, no back-pressure; a paired block must arrive on both lanes in one cycle, lane 0 older
`timescale 1ns/1ps
`default_nettype none

module bp_update_buffer #(
    parameter int DEPTH = 6
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic [1:0]          res_valid,
    input  bp_pkg::bp_resolve_t res0,
    input  bp_pkg::bp_resolve_t res1,
    output logic                upd_valid,
    output bp_pkg::bp_update_t  upd
);

    import bp_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    bp_resolve_t      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr_1;
    logic [CNT_W-1:0] count;
    logic [1:0]       n_in;
    logic [1:0]       n_out;
    bp_resolve_t      head;
    bp_resolve_t      partner;
    logic             paired;
    logic             pair_ok;
    bp_update_t       merged;

    function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] p, input logic [1:0] n);
        logic [PTR_W:0] s;
        s = {1'b0, p} + (PTR_W + 1)'(n);
        if (s >= (PTR_W + 1)'(DEPTH)) begin
            s = s - (PTR_W + 1)'(DEPTH);
        end
        return s[PTR_W-1:0];
    endfunction

    function automatic logic [2:0] kind_rank(input bp_kind_e k);
        case (k)
            direct_jump:   return 3'd5;
            call:          return 3'd4;
            ret:           return 3'd3;
            indirect_jump: return 3'd2;
            other_jump:    return 3'd1;
            default:       return 3'd0;
        endcase
    endfunction

    function automatic bp_kind_e merge_kind(input bp_kind_e a, input bp_kind_e b);
        return (kind_rank(a) >= kind_rank(b)) ? a : b;
    endfunction

    assign n_in     = {1'b0, res_valid[0]} + {1'b0, res_valid[1]};
    assign wr_ptr_1 = ptr_add(wr_ptr, 2'd1);

    // lane 0 takes the first free slot when both lanes fire
    always_ff @(posedge clk) begin
        if (res_valid[0]) begin
            mem[wr_ptr] <= res0;
        end
        if (res_valid == 2'b11) begin
            mem[wr_ptr_1] <= res1;
        end else if (res_valid == 2'b10) begin
            mem[wr_ptr] <= res1;
        end
    end

    always_comb begin
        head    = mem[rd_ptr];
        partner = mem[ptr_add(rd_ptr, 2'd1)];
        paired  = head.pack_size && !head.flush_pre;
        pair_ok = paired && (count > CNT_W'(1));

        if (count == '0) begin
            n_out = 2'd0;
        end else if (pair_ok) begin
            n_out = 2'd2;
        end else begin
            n_out = 2'd1;
        end

        merged.pc  = head.ex.pc;
        merged.bh  = head.pred.bh;
        merged.cnt = head.pred.cnt;
        if (pair_ok) begin
            merged.taken = head.ex.taken || partner.ex.taken;
            merged.kind  = merge_kind(head.ex.kind, partner.ex.kind);
            merged.npc   = head.ex.taken ? head.ex.npc : partner.ex.npc; // older wins if taken
        end else begin
            merged.taken = head.ex.taken;
            merged.kind  = head.ex.kind;
            merged.npc   = head.ex.npc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            upd_valid <= 1'b0;
        end else begin
            wr_ptr    <= ptr_add(wr_ptr, n_in);
            rd_ptr    <= ptr_add(rd_ptr, n_out);
            count     <= count + CNT_W'(n_in) - CNT_W'(n_out);
            upd_valid <= (n_out != 2'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (n_out != 2'd0) begin
            upd <= merged;
        end
    end

    // execute never has more than DEPTH records in flight
    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        (int'(count) + int'(n_in)) <= (DEPTH + int'(n_out)));

    // both halves of a block are enqueued together, so the partner is already here
    a_pair_present: assert property (@(posedge clk) disable iff (!rstn)
        ((count != '0) && paired) |-> (count > CNT_W'(1)));

endmodule

`default_nettype wire

/* src/bp_updater.sv */
// trains from the counter snapshot carried in the update, not from the current table value
`timescale 1ns/1ps
`default_nettype none

module bp_updater #(
    parameter int INDEX_W = 6
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     upd_valid,
    input  bp_pkg::bp_update_t       upd,
    output logic                     pht_wr_en,
    output logic                     btb_wr_en,
    output logic [INDEX_W-1:0]       pht_addr,
    output logic [INDEX_W-1:0]       btb_addr,
    output bp_pkg::bp_cnt_t          pht_data,
    output bp_pkg::bp_btb_t          btb_data,
    output logic [bp_pkg::GHR_W-1:0] ghr
);

    import bp_pkg::*;

    logic [GHR_W-1:0] pht_hash;

    assign pht_hash = bp_index(upd.pc, upd.bh); // same hash as at lookup
    assign pht_addr = pht_hash[INDEX_W-1:0];
    assign btb_addr = upd.pc[INDEX_W-1:0];

    // saturating 2-bit counter
    always_comb begin
        if (upd.taken) begin
            pht_data = (upd.cnt == 2'b11) ? upd.cnt : upd.cnt + 2'b01;
        end else begin
            pht_data = (upd.cnt == 2'b00) ? upd.cnt : upd.cnt - 2'b01;
        end
    end

    always_comb begin
        btb_data.valid  = 1'b1;
        btb_data.tag    = bp_tag(upd.pc, INDEX_W);
        btb_data.kind   = upd.kind;
        btb_data.target = upd.npc;
    end

    assign pht_wr_en = upd_valid;
    assign btb_wr_en = upd_valid && upd.taken; // only taken blocks allocate

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ghr <= '0;
        end else if (upd_valid) begin
            ghr <= {ghr[GHR_W-2:0], upd.taken};
        end
    end

    a_wr_needs_upd: assert property (@(posedge clk) disable iff (!rstn)
        (pht_wr_en || btb_wr_en) |-> upd_valid);

endmodule

`default_nettype wire
